/* logic/rv32_pkg.sv */
package rv32_pkg;

    // Datapath width, fixed by RV32I
    localparam int xlen = 32;

    // Register file geometry
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_e;

    // ALU operation select
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_e;

    // Decode to execute register
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        alu_op_e               op;
        // Operands after forwarding and immediate select
        logic [xlen-1:0]       a;
        logic [xlen-1:0]       b;
        logic [reg_addr_w-1:0] rd;
        // Clear for x0 targets, illegal words and bubbles
        logic                  we;
    } decode_out_t;

    // Computed result, also the retire report
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic                  we;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        logic                  zero;
    } exec_out_t;

endpackage

/* logic/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            we,
    input  logic [rv32_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv32_pkg::xlen-1:0]       wdata,
    input  logic [rv32_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv32_pkg::reg_addr_w-1:0] raddr2,
    output logic [rv32_pkg::xlen-1:0]       rdata1,
    output logic [rv32_pkg::xlen-1:0]       rdata2
);

    import rv32_pkg::*;

    // x0 has no storage, only x1..x31 are kept
    logic [xlen-1:0] regs [1:num_regs-1];

    // Single write port, writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational reads
    // A same-cycle write is not visible here, decode forwards from retire instead
    always_comb begin
        rdata1 = '0;
        rdata2 = '0;
        if (raddr1 != '0) begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 != '0) begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

/* logic/instr_decode.sv */
`timescale 1ns/10ps

module instr_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    input  rv32_pkg::exec_out_t   exe,
    input  rv32_pkg::exec_out_t   retire,
    output rv32_pkg::decode_out_t dec
);

    import rv32_pkg::*;

    // Instruction fields
    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;

    // Decode results
    alu_op_e               op;
    logic                  legal;
    logic                  use_imm;
    logic                  is_lui;
    logic [xlen-1:0]       imm;

    // Operands
    logic [xlen-1:0]       rf_data1;
    logic [xlen-1:0]       rf_data2;
    logic [xlen-1:0]       src1;
    logic [xlen-1:0]       src2;
    decode_out_t           dec_next;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // Written from the retire register, one edge after it is reported
    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (retire.valid & retire.we),
        .waddr  (retire.rd),
        .wdata  (retire.data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2)
    );

    // Opcode and function code mapping
    always_comb begin
        op      = alu_add;
        legal   = 1'b1;
        use_imm = 1'b0;
        is_lui  = 1'b0;
        // I-type immediate, sign extended
        imm     = {{20{instr[31]}}, instr[31:20]};
        case (opcode)
            op_reg: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  op = alu_add;
                        3'b001:  op = alu_sll;
                        3'b010:  op = alu_slt;
                        3'b011:  op = alu_sltu;
                        3'b100:  op = alu_xor;
                        3'b101:  op = alu_srl;
                        3'b110:  op = alu_or;
                        default: op = alu_and;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op = alu_sub;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    op = alu_sra;
                end else begin
                    legal = 1'b0;
                end
            end
            op_imm: begin
                use_imm = 1'b1;
                case (funct3)
                    3'b000:  op = alu_add;
                    3'b010:  op = alu_slt;
                    3'b011:  op = alu_sltu;
                    3'b100:  op = alu_xor;
                    3'b110:  op = alu_or;
                    3'b111:  op = alu_and;
                    3'b001: begin
                        // Shift amount is shamt, bits 24:20, zero extended
                        op    = alu_sll;
                        imm   = {27'b0, instr[24:20]};
                        legal = (funct7 == 7'b0000000);
                    end
                    default: begin
                        imm = {27'b0, instr[24:20]};
                        if (funct7 == 7'b0000000) begin
                            op = alu_srl;
                        end else if (funct7 == 7'b0100000) begin
                            op = alu_sra;
                        end else begin
                            legal = 1'b0;
                        end
                    end
                endcase
            end
            op_lui: begin
                // Computed as 0 + imm
                is_lui  = 1'b1;
                use_imm = 1'b1;
                imm     = {instr[31:12], 12'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    // Execute result has priority over retire, then the register file
    function automatic logic [xlen-1:0] fwd_sel(
        input logic [reg_addr_w-1:0] rs,
        input logic [xlen-1:0]       rf_data,
        input exec_out_t             ex,
        input exec_out_t             rt
    );
        logic [xlen-1:0] val;
        val = rf_data;
        if (rs != '0) begin
            if (ex.valid && ex.we && ex.rd == rs) begin
                val = ex.data;
            end else if (rt.valid && rt.we && rt.rd == rs) begin
                val = rt.data;
            end
        end
        return val;
    endfunction

    assign src1 = fwd_sel(rs1, rf_data1, exe, retire);
    assign src2 = fwd_sel(rs2, rf_data2, exe, retire);

    // Next decode register contents
    always_comb begin
        dec_next.valid   = instr_valid;
        dec_next.illegal = instr_valid & ~legal;
        dec_next.op      = op;
        dec_next.a       = is_lui ? '0 : src1;
        dec_next.b       = use_imm ? imm : src2;
        dec_next.rd      = rd;
        // No write for bubbles, illegal words or x0
        dec_next.we      = instr_valid & legal & (rd != '0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec <= '0;
        end else begin
            dec <= dec_next;
        end
    end

endmodule

/* logic/alu.sv */
`timescale 1ns/10ps

module alu (
    input  rv32_pkg::decode_out_t dec,
    output rv32_pkg::exec_out_t   exe
);

    import rv32_pkg::*;

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [4:0]      shamt;
    logic [xlen-1:0] result;

    assign a     = dec.a;
    assign b     = dec.b;
    // Only the low five bits of b count for shifts
    assign shamt = b[4:0];

    always_comb begin
        case (dec.op)
            alu_add: begin
                // Carry out is dropped
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_slt: begin
                if (a[xlen-1] != b[xlen-1]) begin
                    // Signs differ, the negative one is smaller
                    result = {{(xlen-1){1'b0}}, a[xlen-1]};
                end else begin
                    // Same sign, the rest compares as unsigned
                    result = {{(xlen-1){1'b0}}, (a[xlen-2:0] < b[xlen-2:0])};
                end
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, (a < b)};
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                // Sign bit fills from the left
                result = $signed(a) >>> shamt;
            end
            default: result = '0;
        endcase
    end

    // Control fields pass through untouched
    always_comb begin
        exe.valid   = dec.valid;
        exe.illegal = dec.illegal;
        exe.we      = dec.we;
        exe.rd      = dec.rd;
        exe.data    = result;
        exe.zero    = (result == '0);
    end

endmodule

/* logic/result_stage.sv */
`timescale 1ns/10ps

module result_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  rv32_pkg::exec_out_t exe,
    output rv32_pkg::exec_out_t retire
);

    // Captures the execute result every cycle
    // Bubbles come through with valid low and are reported as such
    // The same register is the pending register-file write, so decode
    // forwards from it until the write lands on the next edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire <= '0;
        end else begin
            retire <= exe;
        end
    end

endmodule

/* logic/rv32_alu_core.sv */
`timescale 1ns/10ps

module rv32_alu_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  logic [31:0]         instr,
    output rv32_pkg::exec_out_t retire
);

    import rv32_pkg::*;

    // Decode register to execute
    decode_out_t dec;
    // Execute result, also first forwarding source
    exec_out_t   exe;

    // Decode, operand read and decode register
    instr_decode u_instr_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .exe         (exe),
        .retire      (retire),
        .dec         (dec)
    );

    // Combinational execute
    alu u_alu (
        .dec (dec),
        .exe (exe)
    );

    // Result register, drives retire and the register-file write
    result_stage u_result_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .exe    (exe),
        .retire (retire)
    );

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    localparam int half_period = 2;

    always #half_period clk = ~clk;

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        // Held low over two rising edges, released just after the second
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

/* bench/tb_rv32_alu_core.sv */
`timescale 1ns/10ps

module tb_rv32_alu_core;

    import rv32_pkg::*;

    localparam logic [31:0] seed          = 32'h3fc1;
    localparam int          num_instrs    = 400;
    localparam int          reset_timeout = 20;
    localparam int          drain_timeout = 20;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    exec_out_t   retire;

    // Architectural state of the model
    logic [31:0] model_regs [0:31];
    logic [31:0] lcg_state;
    int          edge_count = 0;
    int          mismatch_count = 0;
    int          protocol_count = 0;
    int          timeout_count = 0;

    // Expected retires in program order with the edge each must land on
    exec_out_t   exp_q [$];
    int          exp_edge_q [$];
    bit          dump_q [$];

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv32_alu_core dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .retire      (retire)
    );

    always @(posedge clk) edge_count <= edge_count + 1;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Small register set so dependencies are frequent
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        return 5'(int'(r[31:24]) % 6);
    endfunction

    // Operation select 0..9 is add sub sll slt sltu xor srl sra or and
    function automatic logic [2:0] funct3_of(input int sel);
        case (sel)
            0, 1:    return 3'b000;
            2:       return 3'b001;
            3:       return 3'b010;
            4:       return 3'b011;
            5:       return 3'b100;
            6, 7:    return 3'b101;
            8:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [6:0] funct7_of(input int sel);
        return (sel == 1 || sel == 7) ? 7'b0100000 : 7'b0000000;
    endfunction

    // RV32I semantics with shifts by the low five bits of b
    function automatic logic [31:0] model_alu(input int sel, input logic [31:0] a,
                                              input logic [31:0] b);
        case (sel)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4:       return (a < b) ? 32'd1 : 32'd0;
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return $signed(a) >>> b[4:0];
            8:       return a | b;
            default: return a & b;
        endcase
    endfunction

    // Builds the expected report and commits the write to the model
    task automatic apply_model(input logic [4:0] rd, input logic [31:0] data,
                               input bit illegal, output exec_out_t e);
        e.valid   = 1'b1;
        e.illegal = illegal;
        e.we      = !illegal && (rd != 5'd0);
        e.rd      = rd;
        e.data    = data;
        e.zero    = (data == 32'd0);
        if (e.we) begin
            model_regs[rd] = data;
        end
    endtask

    task automatic issue(input logic [31:0] word, input exec_out_t exp, input bit is_dump);
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = word;
        // Sampled on the next edge and reported one edge later
        exp_q.push_back(exp);
        exp_edge_q.push_back(edge_count + 2);
        dump_q.push_back(is_dump);
    endtask

    task automatic drive_bubble();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        // Garbage on instr must be ignored
        instr       = next_rand();
    endtask

    task automatic issue_random();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [31:0] b;
        logic [31:0] word;
        int          kind;
        int          sel;
        exec_out_t   exp;
        r     = next_rand();
        r2    = next_rand();
        kind  = int'(r[31:24]) % 10;
        sel   = int'(r[23:16]) % 10;
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        imm12 = r2[31:20];
        if (kind < 4 || kind == 9) begin
            word = {funct7_of(sel), rs2, rs1, funct3_of(sel), rd, 7'b0110011};
            apply_model(rd, model_alu(sel, model_regs[rs1], model_regs[rs2]), 1'b0, exp);
        end else if (kind < 7) begin
            // No SUBI in RV32I
            if (sel == 1) begin
                sel = 0;
            end
            if (sel == 2 || sel == 6 || sel == 7) begin
                imm12 = {funct7_of(sel), r2[24:20]};
                b     = {27'd0, r2[24:20]};
            end else begin
                b     = {{20{imm12[11]}}, imm12};
            end
            word = {imm12, rs1, funct3_of(sel), rd, 7'b0010011};
            apply_model(rd, model_alu(sel, model_regs[rs1], b), 1'b0, exp);
        end else if (kind == 7) begin
            word = {r2[31:12], rd, 7'b0110111};
            apply_model(rd, {r2[31:12], 12'd0}, 1'b0, exp);
        end else begin
            // Load opcode, M-extension funct7, or SLLI with a bad funct7
            case (sel % 3)
                0:       word = {r2[31:12], rd, 7'b0000011};
                1:       word = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
                default: word = {7'b0100000, r2[24:20], rs1, 3'b001, rd, 7'b0010011};
            endcase
            apply_model(rd, 32'd0, 1'b1, exp);
        end
        issue(word, exp, 1'b0);
    endtask

    // ADD x0, xi, x0 reads each register without changing state
    task automatic dump_regs();
        logic [31:0] word;
        exec_out_t   exp;
        for (int i = 0; i < 32; i++) begin
            word = {7'd0, 5'd0, 5'(i), 3'b000, 5'd0, 7'b0110011};
            apply_model(5'd0, model_regs[i], 1'b0, exp);
            issue(word, exp, 1'b1);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED %s: got %h expected %h", name, got, exp);
        mismatch_count++;
    endtask

    task automatic compare_retire(input exec_out_t got, input exec_out_t exp);
        if (got.illegal !== exp.illegal) report_mismatch("retire.illegal", 32'(got.illegal),
                                                         32'(exp.illegal));
        if (got.we !== exp.we) report_mismatch("retire.we", 32'(got.we), 32'(exp.we));
        if (got.rd !== exp.rd) report_mismatch("retire.rd", 32'(got.rd), 32'(exp.rd));
        // Data of an illegal word carries no meaning
        if (!exp.illegal) begin
            if (got.data !== exp.data) report_mismatch("retire.data", got.data, exp.data);
            if (got.zero !== exp.zero) report_mismatch("retire.zero", 32'(got.zero),
                                                       32'(exp.zero));
        end
    endtask

    task automatic compare_dump(input exec_out_t got, input exec_out_t exp);
        if (got.data !== exp.data) report_mismatch("dump retire.data", got.data, exp.data);
        if (got.zero !== exp.zero) report_mismatch("dump retire.zero", 32'(got.zero),
                                                   32'(exp.zero));
    endtask

    // Retire monitor sampled mid-cycle where retire is stable
    always @(negedge clk) begin
        if (!rst_n && retire.valid) begin
            $display("retire valid went high during reset");
            protocol_count++;
        end
        if (rst_n && retire.valid) begin
            if (exp_q.size() == 0) begin
                $display("retire at edge %0d with no instruction in flight", edge_count);
                protocol_count++;
            end else begin
                if (exp_edge_q[0] != edge_count) begin
                    $display("retire at edge %0d, expected at edge %0d", edge_count,
                             exp_edge_q[0]);
                    protocol_count++;
                end
                if (dump_q[0]) compare_dump(retire, exp_q[0]);
                else compare_retire(retire, exp_q[0]);
                void'(exp_q.pop_front());
                void'(exp_edge_q.pop_front());
                void'(dump_q.pop_front());
            end
        end
        if (exp_edge_q.size() > 0 && exp_edge_q[0] <= edge_count) begin
            $display("no retire at edge %0d for an issued instruction", exp_edge_q[0]);
            protocol_count++;
            void'(exp_q.pop_front());
            void'(exp_edge_q.pop_front());
            void'(dump_q.pop_front());
        end
    end

    initial begin
        int          waited;
        logic [31:0] r;
        instr_valid = 1'b0;
        instr       = '0;
        lcg_state   = seed;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        waited = 0;
        while (rst_n !== 1'b1 && waited < reset_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout waiting for reset release");
            timeout_count++;
        end else begin
            // All registers read zero out of reset
            dump_regs();
            for (int n = 0; n < num_instrs; n++) begin
                r = next_rand();
                if (r[31:24] < 8'd51) drive_bubble();
                else issue_random();
            end
            dump_regs();
            drive_bubble();
            waited = 0;
            while (exp_q.size() > 0 && waited < drain_timeout) begin
                @(negedge clk);
                waited++;
            end
            if (exp_q.size() > 0) begin
                $display("timeout with %0d instructions never retired", exp_q.size());
                timeout_count++;
            end
        end
        $display("errors: %0d mismatches, %0d protocol, %0d timeouts", mismatch_count,
                 protocol_count, timeout_count);
        if (mismatch_count + protocol_count + timeout_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* files.f */
logic/rv32_pkg.sv
logic/reg_file.sv
logic/instr_decode.sv
logic/alu.sv
logic/result_stage.sv
logic/rv32_alu_core.sv
bench/tb_clock_gen.sv
bench/tb_rv32_alu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run the testbench, then scan the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f files.f --top-module tb_rv32_alu_core -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log

# Any failure in the run prints the fail message
grep -q "test failed" sim.log && { echo "simulation reported failure"; exit 1; }

echo "simulation clean"
exit 0
